//--- common/booth_mult_config.svh
//####################
// width and digit-count macros of the
// 16x16 Booth multiplier, plus the
// sign-extension completion constant
//####################
`ifndef BOOTH_MULT_CONFIG_SVH
`define BOOTH_MULT_CONFIG_SVH

// operand and product widths
`define BM_OPND_W 16
`define BM_PROD_W 32

// one raw row is the operand plus one bit for the x2 case
`define BM_ROW_W 17

// radix-4 digits, split over two half trees
`define BM_DIGITS 8
`define BM_HALF_DIGITS 4

// ones at bits 16,17,19,21,..,31
// cancels the 2^(16+2k) that each inverted row MSB adds
`define BM_SIGN_COMP 32'hAAAB_0000

`endif

//--- common/booth_mult_pkg.sv
//####################
// vector types shared by the multiplier
// operand word, raw Booth row and the
// 32-bit placed row / product word
//####################
`include "booth_mult_config.svh"

package booth_mult_pkg;

	// one multiplicand or multiplier word
	typedef logic [`BM_OPND_W-1:0] opnd_t;

	// multiplicand times 0, +-1 or +-2, MSB inverted
	typedef logic [`BM_ROW_W-1:0] row_t;

	// placed rows, carry-save vectors and the product
	typedef logic [`BM_PROD_W-1:0] prod_t;

endpackage

//--- hdl/csa42_row.sv
//####################
// 32-bit row of 4:2 compressors
// four vectors in, sum/carry pair out
//####################
`timescale 1ns/1ps
`include "booth_mult_config.svh"

module csa42_row (
	input  booth_mult_pkg::prod_t i_a,
	input  booth_mult_pkg::prod_t i_b,
	input  booth_mult_pkg::prod_t i_c,
	input  booth_mult_pkg::prod_t i_d,
	output booth_mult_pkg::prod_t o_sum,
	output booth_mult_pkg::prod_t o_carry
);
	import booth_mult_pkg::*;

	prod_t xor_ab;
	prod_t xor_cd;
	prod_t xor_all;
	prod_t cout;
	prod_t cin;
	prod_t carry;

	assign xor_ab = i_a ^ i_b;
	assign xor_cd = i_c ^ i_d;
	assign xor_all = xor_ab ^ xor_cd;

	// inner carry depends on the inputs only, so no ripple
	assign cout = (i_a & i_b) | (i_c & i_d);
	assign cin = {cout[`BM_PROD_W-2:0], 1'b0};

	assign carry = (i_a & i_b & i_c & i_d) | (xor_ab & xor_cd) | (xor_all & cin);

	assign o_sum = xor_all ^ cin;
	// weight 2, bits past 31 drop out
	assign o_carry = {carry[`BM_PROD_W-2:0], 1'b0};

endmodule

//--- partial/booth_pp_row.sv
//####################
// radix-4 Booth encoder for one digit
// and its placed partial-product row
// with the negation correction bit
//####################
`timescale 1ns/1ps
`include "booth_mult_config.svh"

module booth_pp_row #(
	parameter int DIGIT = 0
) (
	input  booth_mult_pkg::opnd_t i_md,
	input  logic [2:0]            i_window,
	output booth_mult_pkg::prod_t o_row,
	output booth_mult_pkg::prod_t o_corr
);
	import booth_mult_pkg::*;

	localparam int MSB = `BM_OPND_W - 1;
	// row weight is 4^DIGIT
	localparam int SHIFT = 2 * DIGIT;

	logic  sel_zero;
	logic  sel_double;
	logic  sel_neg;
	opnd_t md_inv;
	opnd_t md_sel;
	row_t  row;

	// 000 and 111 select zero
	assign sel_zero = (i_window == 3'b000) || (i_window == 3'b111);
	// 011 -> +2, 100 -> -2
	assign sel_double = (i_window == 3'b011) || (i_window == 3'b100);
	assign sel_neg = i_window[2] & ~sel_zero;

	// one's complement now, the +1 goes out on o_corr
	assign md_inv = sel_neg ? ~i_md : i_md;
	assign md_sel = sel_zero ? '0 : md_inv;

	// x2 shifts left, negate fills the freed LSB with ones
	always_comb begin
		if (sel_double) begin
			row = {~md_sel[MSB], md_sel[MSB-1:0], sel_neg};
		end else begin
			row = {~md_sel[MSB], md_sel};
		end
	end

	assign o_row = prod_t'(row) << SHIFT;
	assign o_corr = prod_t'(sel_neg) << SHIFT;

endmodule

//--- partial/booth_half_tree.sv
//####################
// half of the reduction tree
// four Booth rows -> 4:2 row -> 3:2 step
// with the ORed negation corrections
//####################
`timescale 1ns/1ps
`include "booth_mult_config.svh"

module booth_half_tree #(
	parameter int FIRST_DIGIT = 0
) (
	input  booth_mult_pkg::opnd_t i_md,
	input  booth_mult_pkg::opnd_t i_mr,
	output booth_mult_pkg::prod_t o_sum,
	output booth_mult_pkg::prod_t o_carry
);
	import booth_mult_pkg::*;

	// multiplier with the implicit zero below bit 0
	logic [`BM_OPND_W:0] mr_ext;
	prod_t               rows [`BM_HALF_DIGITS];
	prod_t               corrs [`BM_HALF_DIGITS];
	prod_t               corr_all;
	prod_t               csa_sum;
	prod_t               csa_carry;
	prod_t               maj;

	assign mr_ext = {i_mr, 1'b0};

	for (genvar j = 0; j < `BM_HALF_DIGITS; j++) begin : g_row
		booth_pp_row #(
			.DIGIT(FIRST_DIGIT + j)
		) u_pp_row (
			.i_md(i_md),
			.i_window(mr_ext[2*(FIRST_DIGIT+j)+2 -: 3]),
			.o_row(rows[j]),
			.o_corr(corrs[j])
		);
	end

	csa42_row u_csa42 (
		.i_a(rows[0]),
		.i_b(rows[1]),
		.i_c(rows[2]),
		.i_d(rows[3]),
		.o_sum(csa_sum),
		.o_carry(csa_carry)
	);

	// correction bits sit on distinct even columns
	assign corr_all = corrs[0] | corrs[1] | corrs[2] | corrs[3];

	// 3:2 step folds the corrections in
	assign maj = (csa_sum & csa_carry) | (csa_sum & corr_all) | (csa_carry & corr_all);
	assign o_sum = csa_sum ^ csa_carry ^ corr_all;
	assign o_carry = {maj[`BM_PROD_W-2:0], 1'b0};

endmodule

//--- hdl/product_combine.sv
//####################
// merges both half-tree pairs, adds the
// sign-extension constant and does the
// final carry-propagate add
//####################
`timescale 1ns/1ps
`include "booth_mult_config.svh"

module product_combine (
	input  booth_mult_pkg::prod_t i_sum_lo,
	input  booth_mult_pkg::prod_t i_carry_lo,
	input  booth_mult_pkg::prod_t i_sum_hi,
	input  booth_mult_pkg::prod_t i_carry_hi,
	output booth_mult_pkg::prod_t o_product
);
	import booth_mult_pkg::*;

	// completes the inverted-MSB sign extension of all rows
	localparam prod_t SIGN_COMP = `BM_SIGN_COMP;

	prod_t red_sum;
	prod_t red_carry;
	prod_t maj;
	prod_t fin_sum;
	prod_t fin_carry;

	// four vectors down to two
	csa42_row u_csa42 (
		.i_a(i_sum_lo),
		.i_b(i_carry_lo),
		.i_c(i_sum_hi),
		.i_d(i_carry_hi),
		.o_sum(red_sum),
		.o_carry(red_carry)
	);

	// 3:2 with the constant ones
	assign maj = (red_sum & red_carry) | (red_sum & SIGN_COMP) | (red_carry & SIGN_COMP);
	assign fin_sum = red_sum ^ red_carry ^ SIGN_COMP;
	assign fin_carry = {maj[`BM_PROD_W-2:0], 1'b0};

	// carry out drops for a result modulo 2^32
	assign o_product = fin_sum + fin_carry;

endmodule

//--- hdl/booth_mult.sv
//####################
// pipelined signed 16x16 Booth multiplier
// stage 0: operand register + half trees
// stage 1: mid-tree register + final add
// o_ready two edges after i_start
//####################
`timescale 1ns/1ps
`include "booth_mult_config.svh"

module booth_mult (
	input  logic                  i_clk,
	input  logic                  i_rst,
	input  logic                  i_start,
	input  booth_mult_pkg::opnd_t i_md,
	input  booth_mult_pkg::opnd_t i_mr,
	output booth_mult_pkg::prod_t o_product,
	output logic                  o_ready
);
	import booth_mult_pkg::*;

	opnd_t md_q;
	opnd_t mr_q;
	logic  s0_valid;
	prod_t sum_lo;
	prod_t carry_lo;
	prod_t sum_hi;
	prod_t carry_hi;
	prod_t sum_lo_q;
	prod_t carry_lo_q;
	prod_t sum_hi_q;
	prod_t carry_hi_q;

	// operand capture
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			md_q <= '0;
			mr_q <= '0;
			s0_valid <= 1'b0;
		end else begin
			if (i_start) begin
				md_q <= i_md;
				mr_q <= i_mr;
			end
			s0_valid <= i_start;
		end
	end

	// digits 0-3
	booth_half_tree #(
		.FIRST_DIGIT(0)
	) u_half_lo (
		.i_md(md_q),
		.i_mr(mr_q),
		.o_sum(sum_lo),
		.o_carry(carry_lo)
	);

	// digits 4-7
	booth_half_tree #(
		.FIRST_DIGIT(`BM_DIGITS - `BM_HALF_DIGITS)
	) u_half_hi (
		.i_md(md_q),
		.i_mr(mr_q),
		.o_sum(sum_hi),
		.o_carry(carry_hi)
	);

	// mid-tree register, holds the last result when idle
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			sum_lo_q <= '0;
			carry_lo_q <= '0;
			sum_hi_q <= '0;
			carry_hi_q <= '0;
			o_ready <= 1'b0;
		end else begin
			if (s0_valid) begin
				sum_lo_q <= sum_lo;
				carry_lo_q <= carry_lo;
				sum_hi_q <= sum_hi;
				carry_hi_q <= carry_hi;
			end
			o_ready <= s0_valid;
		end
	end

	product_combine u_combine (
		.i_sum_lo(sum_lo_q),
		.i_carry_lo(carry_lo_q),
		.i_sum_hi(sum_hi_q),
		.i_carry_hi(carry_hi_q),
		.o_product(o_product)
	);

endmodule

//--- bench/tb_booth_mult_tasks.svh
//####################
// driving, waiting and compare tasks
// for the Booth multiplier testbench
//####################
`ifndef TB_BOOTH_MULT_TASKS_SVH
`define TB_BOOTH_MULT_TASKS_SVH

// signed product of the sign-extended operands, kept to 32 bits
function automatic prod_t expected_product(input opnd_t a, input opnd_t b);
	logic signed [31:0] sa;
	logic signed [31:0] sb;
	sa = {{16{a[15]}}, a};
	sb = {{16{b[15]}}, b};
	return prod_t'(sa * sb);
endfunction

task automatic check_prod(input string name, input prod_t got, input prod_t exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		fail_run();
	end
endtask

task automatic check_ready(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
		fail_run();
	end
endtask

// fixed number of cycles with no start pending
task automatic idle_cycles(input int n);
	repeat (n) begin
		@(posedge i_clk);
		#1;
		check_ready("o_ready", o_ready, 1'b0);
	end
endtask

// one start, then wait for its single ready pulse
task automatic do_mult(input opnd_t md, input opnd_t mr);
	int edges;
	i_md = md;
	i_mr = mr;
	i_start = 1'b1;
	edges = 0;
	do begin
		@(posedge i_clk);
		#1;
		i_start = 1'b0;
		edges++;
		if (edges > 10) begin
			$display("timeout: no o_ready within 10 cycles of a start");
			fail_run();
		end
	end while (!o_ready);
	if (edges != 2) begin
		$display("o_ready came %0d edges after the start instead of 2", edges);
		fail_run();
	end
	last_prod = expected_product(md, mr);
	check_prod("o_product", o_product, last_prod);
	// pulse lasts one cycle, result stays
	@(posedge i_clk);
	#1;
	check_ready("o_ready", o_ready, 1'b0);
	check_prod("o_product", o_product, last_prod);
endtask

// operands change but i_start stays low
task automatic hold_idle(input int n);
	opnd_t val;
	repeat (n) begin
		take_bits(16, val);
		i_md = val;
		take_bits(16, val);
		i_mr = val;
		@(posedge i_clk);
		#1;
		check_ready("o_ready", o_ready, 1'b0);
		check_prod("o_product", o_product, last_prod);
	end
endtask

// n starts, each result due two edges after its own start
task automatic run_stream(input int n, input bit with_gaps);
	prod_t exp_q[$];
	int    issue_q[$];
	int    issued;
	int    done;
	int    cycle;
	int    gap;
	logic  exp_ready;
	opnd_t md;
	opnd_t mr;
	opnd_t bits;
	issued = 0;
	done = 0;
	cycle = 0;
	gap = 0;
	while (done < n) begin
		if (cycle > 6 * n + 10) begin
			$display("timeout: only %0d of %0d results arrived", done, n);
			fail_run();
		end
		exp_ready = (issue_q.size() > 0) && (issue_q[0] + 2 == cycle);
		check_ready("o_ready", o_ready, exp_ready);
		if (exp_ready) begin
			check_prod("o_product", o_product, exp_q[0]);
			last_prod = exp_q.pop_front();
			void'(issue_q.pop_front());
			done++;
		end
		if (issued < n && gap == 0) begin
			take_bits(16, md);
			take_bits(16, mr);
			i_md = md;
			i_mr = mr;
			i_start = 1'b1;
			exp_q.push_back(expected_product(md, mr));
			issue_q.push_back(cycle);
			issued++;
			if (with_gaps) begin
				take_bits(2, bits);
				gap = int'(bits[1:0]);
			end
		end else begin
			i_start = 1'b0;
			if (gap > 0) begin
				gap--;
			end
		end
		@(posedge i_clk);
		#1;
		cycle++;
	end
	i_start = 1'b0;
	check_ready("o_ready", o_ready, 1'b0);
endtask

`endif

//--- bench/tb_booth_mult.sv
//####################
// testbench top for the Booth multiplier
// clock, reset, DUT, LFSR operand source
// and the directed test sequence
//####################
`timescale 1ns/1ps

module tb_booth_mult;
	import booth_mult_pkg::*;

	logic  i_clk;
	logic  i_rst;
	logic  i_start;
	opnd_t i_md;
	opnd_t i_mr;
	prod_t o_product;
	logic  o_ready;

	// operand source state
	logic [15:0] lfsr_state;
	// product that o_product should hold when idle
	prod_t       last_prod;

	booth_mult dut0 (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_start(i_start),
		.i_md(i_md),
		.i_mr(i_mr),
		.o_product(o_product),
		.o_ready(o_ready)
	);

	// 10 ns period
	always #5 i_clk = ~i_clk;

	// galois form, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] next_lfsr(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit, newest bit at the LSB
	task automatic take_bits(input int n, output opnd_t val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[14:0], lfsr_state[0]};
			lfsr_state = next_lfsr(lfsr_state);
		end
	endtask

	task automatic fail_run();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tb_booth_mult_tasks.svh"

	// signed corner cases
	task automatic run_corners();
		do_mult(16'h0000, 16'h1234);
		do_mult(16'h7FFF, 16'h0000);
		do_mult(16'h0001, 16'hFB2E);
		do_mult(16'h4D21, 16'h0001);
		do_mult(16'hFFFF, 16'hFFFF);
		do_mult(16'h7FFF, 16'h7FFF);
		do_mult(16'h8000, 16'h8000);
		do_mult(16'h8000, 16'h7FFF);
		do_mult(16'h7FFF, 16'h8000);
		// alternating bits
		do_mult(16'hAAAA, 16'h5555);
		do_mult(16'h5555, 16'h5555);
		do_mult(16'hAAAA, 16'hAAAA);
	endtask

	initial begin
		opnd_t md;
		opnd_t mr;

		i_clk = 1'b0;
		i_rst = 1'b0;
		i_start = 1'b0;
		i_md = '0;
		i_mr = '0;
		lfsr_state = 16'd65;
		last_prod = '0;

		// reset held for 16 cycles, no ready meanwhile
		repeat (16) begin
			@(posedge i_clk);
			#1;
			check_ready("o_ready", o_ready, 1'b0);
		end
		i_rst = 1'b1;
		idle_cycles(4);

		run_corners();

		for (int n = 0; n < 60; n++) begin
			take_bits(16, md);
			take_bits(16, mr);
			do_mult(md, mr);
		end

		// back to back, then idle with moving operands
		run_stream(20, 1'b0);
		hold_idle(8);

		// random gaps of 0 to 3 cycles
		run_stream(40, 1'b1);
		hold_idle(4);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- booth_mult.f
+incdir+common
+incdir+bench
common/booth_mult_pkg.sv
hdl/csa42_row.sv
partial/booth_pp_row.sv
partial/booth_half_tree.sv
hdl/product_combine.sv
hdl/booth_mult.sv
bench/tb_booth_mult.sv

//--- Makefile
# Verilator flow for the Booth multiplier testbench
# lint checks the whole source list, sim builds and runs the testbench

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f booth_mult.f --top-module tb_booth_mult

sim:
	verilator --binary --timing --timescale 1ns/1ps \
		-f booth_mult.f --top-module tb_booth_mult -o sim_booth_mult
	@out="$$(./obj_dir/sim_booth_mult 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
